/* hw/music_pkg.sv */
package music_pkg;

    // ----------------------------------------------------------------------
    // widths shared by the song memory, the sequencer and the voices
    // ----------------------------------------------------------------------

    // a note index selects one of 64 pitches
    localparam int NOTE_W     = 6;
    // durations and waits are both counted in beats
    localparam int DUR_W      = 6;
    // a song holds up to 256 words
    localparam int ADDR_W     = 8;
    localparam int NUM_VOICES = 3;

    // note view of a song word with the top bit clear
    // a voice_sel of 0 lets the arbiter pick and 1 to 3 force that voice
    typedef struct packed {
        logic              is_wait;
        logic [NOTE_W-1:0] note;
        logic [DUR_W-1:0]  duration;
        logic [1:0]        voice_sel;
        logic              last;
    } song_note_t;

    // wait view of a song word with the top bit set
    typedef struct packed {
        logic             is_wait;
        logic [DUR_W-1:0] beats;
        logic             last;
        logic [7:0]       reserved;
    } song_wait_t;

    // both views keep is_wait in bit 15 so it can pick the view
    typedef union packed {
        song_note_t as_note;
        song_wait_t as_wait;
    } song_word_t;

    // state of one voice with the note reading 0 while the voice is silent
    typedef struct packed {
        logic              active;
        logic [NOTE_W-1:0] note;
    } voice_state_t;

endpackage

/* hw/song_mem.sv */
`timescale 1ns/10ps

// song RAM with one load port and one registered read port
module song_mem #(
    parameter int ADDR_W = music_pkg::ADDR_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic [ADDR_W-1:0]      wr_addr,
    input  music_pkg::song_word_t  wr_word,
    input  logic [ADDR_W-1:0]      rd_addr,
    output music_pkg::song_word_t  rd_word
);

    import music_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    // one song word per address
    song_word_t mem [0:DEPTH-1];

    // the load port writes one word per cycle while wr_en is high
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // ----------------------------------------------------------------------
    // read port
    // ----------------------------------------------------------------------

    // the word for an address shows up one cycle after the address
    // a write to the same address in the same cycle leaves the old word here
    // the read register starts from an all-zero word after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_word <= '0;
        end else begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

/* hw/beat_generator.sv */
`timescale 1ns/10ps

// beat pulse source that gives one pulse every BEAT_CYCLES clocks while run is high
module beat_generator #(
    parameter int BEAT_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic beat
);

    localparam int CNT_W = (BEAT_CYCLES > 1) ? $clog2(BEAT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BEAT_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    // the period restarts whenever run is low, so a resume gives a full first beat
    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            cnt <= '0;
        end else if (cnt == LAST_CNT) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // the pulse sits on the last cycle of each period
    assign beat = run && (cnt == LAST_CNT);

endmodule

/* hw/voice_arbiter.sv */
`timescale 1ns/10ps

// picks the voice that takes the current note word
module voice_arbiter (
    input  logic [music_pkg::NUM_VOICES-1:0] busy,
    input  logic                             dispatch_req,
    input  logic [1:0]                       voice_sel,
    output logic [music_pkg::NUM_VOICES-1:0] grant
);

    import music_pkg::*;

    logic [NUM_VOICES-1:0] free;
    logic [NUM_VOICES-1:0] lowest_free;
    logic [NUM_VOICES-1:0] forced;

    assign free = ~busy;

    // the two's complement trick keeps only the lowest set bit and voice 1 is bit 0
    assign lowest_free = free & (~free + 1'b1);

    // a forced word names voice 1 to 3, which maps to bit 0 to 2
    always_comb begin
        forced = '0;
        if (voice_sel != 2'd0) begin
            forced[voice_sel - 2'd1] = 1'b1;
        end
    end

    // a forced voice that is busy gets nothing and the sequencer then stalls
    assign grant = !dispatch_req       ? '0 :
                   (voice_sel == 2'd0) ? lowest_free :
                                         (forced & free);

endmodule

/* hw/note_player.sv */
`timescale 1ns/10ps

// one voice of the player
// it holds a note for a number of beats and then frees itself
module note_player (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         beat,
    input  logic                         start,
    input  logic [music_pkg::NOTE_W-1:0] start_note,
    input  logic [music_pkg::DUR_W-1:0]  start_duration,
    output logic                         busy,
    output music_pkg::voice_state_t      state
);

    import music_pkg::*;

    // ----------------------------------------------------------------------
    // note and duration
    // ----------------------------------------------------------------------

    logic              active;
    logic [NOTE_W-1:0] note_q;
    logic [DUR_W-1:0]  beats_left;
    logic              last_beat;

    // a note of duration 0 is stretched to a single beat
    logic [DUR_W-1:0]  load_duration;

    assign load_duration = (start_duration == '0) ? DUR_W'(1) : start_duration;

    // the note is latched on start and shown only while active
    always_ff @(posedge clk) begin
        if (start) begin
            note_q <= start_note;
        end
    end

    // beats left in the current note
    // a beat in the same cycle as start does not count against the new note
    always_ff @(posedge clk) begin
        if (start) begin
            beats_left <= load_duration;
        end else if (active && beat) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // active flag
    // ----------------------------------------------------------------------

    // this beat uses up the last count of the note
    assign last_beat = active && beat && (beats_left == DUR_W'(1));

    // active rises the cycle after start and falls the cycle after the last beat
    // with no beats during a pause the note simply keeps sounding
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (last_beat) begin
            active <= 1'b0;
        end
    end

    assign busy = active;

    // a silent voice reports note 0 rather than the stale one
    assign state.active = active;
    assign state.note   = active ? note_q : '0;

endmodule

/* hw/song_reader.sv */
`timescale 1ns/10ps

// song sequencer
// walks the song memory, hands note words to voices and counts wait words
module song_reader #(
    parameter int ADDR_W = music_pkg::ADDR_W
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             play,
    input  logic                             beat,
    input  music_pkg::song_word_t            rd_word,
    input  logic [music_pkg::NUM_VOICES-1:0] grant,
    output logic [ADDR_W-1:0]                rd_addr,
    output logic                             dispatch_req,
    output logic [1:0]                       voice_sel,
    output logic [music_pkg::NUM_VOICES-1:0] start,
    output logic [music_pkg::NOTE_W-1:0]     start_note,
    output logic [music_pkg::DUR_W-1:0]      start_duration,
    output logic                             song_done
);

    import music_pkg::*;

    // fetch covers the cycle the RAM needs and decode is the cycle the word is valid
    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_WAIT
    } state_t;

    state_t           state;
    logic             play_q;
    logic             play_rise;
    logic [DUR_W-1:0] wait_cnt;
    logic             is_wait;
    logic             word_last;
    logic             note_sent;
    logic             wait_done;
    logic             advance;
    logic             at_top;
    logic             finish;

    // ----------------------------------------------------------------------
    // word decode
    // ----------------------------------------------------------------------

    // the top bit picks the view and the end flag sits in a different bit in each
    assign is_wait   = rd_word.as_note.is_wait;
    assign word_last = is_wait ? rd_word.as_wait.last : rd_word.as_note.last;

    // note words ask the arbiter for a voice only while playing
    assign dispatch_req   = (state == S_DECODE) && play && !is_wait;
    assign voice_sel      = rd_word.as_note.voice_sel;
    assign start_note     = rd_word.as_note.note;
    assign start_duration = rd_word.as_note.duration;

    // the grant is one-hot or zero, so at most one voice starts per cycle
    assign start     = dispatch_req ? grant : '0;
    assign note_sent = dispatch_req && (grant != '0);

    // a wait word is done on its last beat or right away when it asks for 0
    always_comb begin
        wait_done = 1'b0;
        if (play) begin
            if ((state == S_DECODE) && is_wait && (rd_word.as_wait.beats == '0)) begin
                wait_done = 1'b1;
            end
            if ((state == S_WAIT) && beat && (wait_cnt == DUR_W'(1))) begin
                wait_done = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // address and end of song
    // ----------------------------------------------------------------------

    // the current word is handled this cycle
    assign advance = note_sent || wait_done;

    // handling the top word also ends the song so the address never wraps
    assign at_top = (rd_addr == '1);
    assign finish = advance && (word_last || at_top);

    // a song restarts only on a fresh rising edge of play
    assign play_rise = play && !play_q;

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------

    // with play low every state holds along with the address and the wait count
    // rd_addr stays put in decode and wait, so the RAM keeps returning the word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rd_addr   <= '0;
            wait_cnt  <= '0;
            song_done <= 1'b0;
            play_q    <= 1'b0;
        end else begin
            play_q    <= play;
            song_done <= 1'b0;
            if (finish) begin
                state     <= S_IDLE;
                rd_addr   <= '0;
                song_done <= 1'b1;
            end else if (advance) begin
                state   <= S_FETCH;
                rd_addr <= rd_addr + 1'b1;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (play_rise) begin
                            state <= S_FETCH;
                        end
                    end
                    S_FETCH: begin
                        if (play) begin
                            state <= S_DECODE;
                        end
                    end
                    S_DECODE: begin
                        // a note with no grant stays here until a voice frees
                        if (play && is_wait) begin
                            wait_cnt <= rd_word.as_wait.beats;
                            state    <= S_WAIT;
                        end
                    end
                    S_WAIT: begin
                        if (play && beat) begin
                            wait_cnt <= wait_cnt - 1'b1;
                        end
                    end
                    default: begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* hw/music_top.sv */
`timescale 1ns/10ps

// three-voice song player
// song RAM, beat source, sequencer, voice arbiter and the note players
module music_top #(
    parameter int ADDR_W      = music_pkg::ADDR_W,
    parameter int BEAT_CYCLES = 16
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            play,
    input  logic                                            load_en,
    input  logic [ADDR_W-1:0]                               load_addr,
    input  music_pkg::song_word_t                           load_data,
    output logic                                            beat,
    output logic                                            song_done,
    output logic [ADDR_W-1:0]                               song_pos,
    output music_pkg::voice_state_t [music_pkg::NUM_VOICES-1:0] voices
);

    import music_pkg::*;

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------

    logic [ADDR_W-1:0]     rd_addr;
    song_word_t            rd_word;
    logic [NUM_VOICES-1:0] busy;
    logic [NUM_VOICES-1:0] grant;
    logic [NUM_VOICES-1:0] start;
    logic                  dispatch_req;
    logic [1:0]            voice_sel;
    logic [NOTE_W-1:0]     start_note;
    logic [DUR_W-1:0]      start_duration;

    // the song position seen outside is the sequencer's read address
    assign song_pos = rd_addr;

    song_mem #(
        .ADDR_W(ADDR_W)
    ) u_song_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (load_en),
        .wr_addr(load_addr),
        .wr_word(load_data),
        .rd_addr(rd_addr),
        .rd_word(rd_word)
    );

    // beats only run while play is high, which freezes the voices on a pause
    beat_generator #(
        .BEAT_CYCLES(BEAT_CYCLES)
    ) u_beat_generator (
        .clk  (clk),
        .rst_n(rst_n),
        .run  (play),
        .beat (beat)
    );

    song_reader #(
        .ADDR_W(ADDR_W)
    ) u_song_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .play          (play),
        .beat          (beat),
        .rd_word       (rd_word),
        .grant         (grant),
        .rd_addr       (rd_addr),
        .dispatch_req  (dispatch_req),
        .voice_sel     (voice_sel),
        .start         (start),
        .start_note    (start_note),
        .start_duration(start_duration),
        .song_done     (song_done)
    );

    voice_arbiter u_voice_arbiter (
        .busy        (busy),
        .dispatch_req(dispatch_req),
        .voice_sel   (voice_sel),
        .grant       (grant)
    );

    // voice 1 sits at index 0
    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        note_player u_note_player (
            .clk           (clk),
            .rst_n         (rst_n),
            .beat          (beat),
            .start         (start[i]),
            .start_note    (start_note),
            .start_duration(start_duration),
            .busy          (busy[i]),
            .state         (voices[i])
        );
    end

endmodule

/* verification/music_props.sv */
`timescale 1ns/10ps

// protocol checks between the sequencer and the three voices
module music_props (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             beat,
    input logic [music_pkg::NUM_VOICES-1:0] start,
    input logic [music_pkg::NUM_VOICES-1:0] busy,
    input logic                             song_done
);

    // a start pulse only lands on a voice that is free in that same cycle
    a_start_free: assert property (@(posedge clk) disable iff (!rst_n)
        (start & busy) == '0)
        else $error("a start pulse went to a busy voice");

    // the arbiter grant is one-hot or empty
    a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(start))
        else $error("more than one voice started in a cycle");

    // end of song is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        song_done |=> !song_done)
        else $error("song_done stayed high for more than one cycle");

    // a voice only goes silent in the cycle after a beat ended its note
    a_fall_on_beat: assert property (@(posedge clk) disable iff (!rst_n)
        (|($past(busy) & ~busy)) |-> $past(beat))
        else $error("a voice went silent without a beat");

endmodule

bind music_top music_props props0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat     (beat),
    .start    (start),
    .busy     (busy),
    .song_done(song_done)
);

/* verification/music_tb.sv */
`timescale 1ns/10ps

module music_tb;

    import music_pkg::*;

    localparam int BEAT_CYCLES  = 16;
    localparam int BEAT_TIMEOUT = 64;

    logic                          clk;
    logic                          rst_n;
    logic                          play;
    logic                          load_en;
    logic [ADDR_W-1:0]             load_addr;
    song_word_t                    load_data;
    logic                          beat;
    logic                          song_done;
    logic [ADDR_W-1:0]             song_pos;
    voice_state_t [NUM_VOICES-1:0] voices;

    // parser state and the expected values of the current vectors line
    int                fd;
    int                r;
    int                sample_no;
    int                hold_no;
    int                hold_cycles;
    logic [7:0]        code;
    logic [8*256-1:0]  skip_line;
    logic [ADDR_W-1:0] addr_in;
    logic [15:0]       word_in;
    logic [31:0]       e_done;
    logic [31:0]       e_pos;
    logic [31:0]       e_v1;
    logic [31:0]       e_v2;
    logic [31:0]       e_v3;

    // cycles seen with play high since it last rose
    int                play_cycles;
    logic              beat_expected;

    music_top #(
        .ADDR_W     (ADDR_W),
        .BEAT_CYCLES(BEAT_CYCLES)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .play     (play),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .beat     (beat),
        .song_done(song_done),
        .song_pos (song_pos),
        .voices   (voices)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // checking helpers
    // ----------------------------------------------------------------------

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure("an output differs from its expected value");
        end
    endtask

    // voice 1 is index 0 of the voices array
    task automatic check_outputs(input string name);
        check_value($sformatf("%s song_done", name), e_done, 32'(song_done));
        check_value($sformatf("%s song_pos", name), e_pos, 32'(song_pos));
        check_value($sformatf("%s voice 1", name), e_v1, 32'(voices[0]));
        check_value($sformatf("%s voice 2", name), e_v2, 32'(voices[1]));
        check_value($sformatf("%s voice 3", name), e_v3, 32'(voices[2]));
    endtask

    // samples on the falling edge and returns inside the beat cycle
    task automatic wait_for_beat(input string name);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < BEAT_TIMEOUT) begin
            @(negedge clk);
            seen = beat;
            cycles++;
        end
        if (!seen) begin
            stop_with_failure($sformatf("no beat pulse within %0d cycles before %s",
                                        BEAT_TIMEOUT, name));
        end
    endtask

    // ----------------------------------------------------------------------
    // beat period
    // ----------------------------------------------------------------------

    // a beat falls on every BEAT_CYCLES-th cycle of play counted from its rise
    // and never while play is low
    always @(negedge clk) begin
        if (!rst_n || !play) begin
            play_cycles = 0;
        end else begin
            play_cycles++;
        end
        beat_expected = (play_cycles != 0) && ((play_cycles % BEAT_CYCLES) == 0);
        if (rst_n) begin
            check_value($sformatf("beat after %0d play cycles", play_cycles),
                        32'(beat_expected), 32'(beat));
        end
    end

    // ----------------------------------------------------------------------
    // reset and then one vectors line at a time
    // ----------------------------------------------------------------------

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        play      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        sample_no = 0;
        hold_no   = 0;
        e_done    = '0;
        e_pos     = '0;
        e_v1      = '0;
        e_v2      = '0;
        e_v3      = '0;
        // everything reads zero during reset and right after it
        // the tenth rising edge is the last one that sees reset low
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i == 9) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            check_outputs($sformatf("reset cycle %0d", i));
            check_value($sformatf("reset cycle %0d beat", i), 32'd0, 32'(beat));
        end
        @(negedge clk);
        check_outputs("after reset");
        check_value("after reset beat", 32'd0, 32'(beat));
        fd = $fopen("verification/music_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("the vectors file could not be opened");
        end
        r = $fscanf(fd, " %c", code);
        while (r == 1) begin
            case (code)
                "#": r = $fgets(skip_line, fd);
                "L": begin
                    r = $fscanf(fd, "%h %h", addr_in, word_in);
                    @(posedge clk);
                    load_en   <= 1'b1;
                    load_addr <= addr_in;
                    load_data <= word_in;
                    @(posedge clk);
                    load_en   <= 1'b0;
                end
                "P": begin
                    r = $fscanf(fd, "%h", word_in);
                    @(posedge clk);
                    play <= word_in[0];
                end
                "E": begin
                    r = $fscanf(fd, "%h %h %h %h %h", e_done, e_pos, e_v1, e_v2, e_v3);
                    sample_no++;
                    wait_for_beat($sformatf("beat sample %0d", sample_no));
                    // the cycle after the beat pulse
                    @(negedge clk);
                    check_outputs($sformatf("beat sample %0d", sample_no));
                end
                "H": begin
                    r = $fscanf(fd, "%d %h %h %h %h %h", hold_cycles, e_done, e_pos,
                                e_v1, e_v2, e_v3);
                    hold_no++;
                    for (int i = 0; i < hold_cycles; i++) begin
                        @(negedge clk);
                        check_outputs($sformatf("hold %0d cycle %0d", hold_no, i));
                        // no beats at all while paused
                        if (!play) begin
                            check_value($sformatf("hold %0d beat", hold_no), 32'd0, 32'(beat));
                        end
                    end
                end
                default: stop_with_failure("the vectors file holds an unknown line type");
            endcase
            r = $fscanf(fd, " %c", code);
        end
        $fclose(fd);
        if (sample_no == 0) begin
            stop_with_failure("the vectors file held no beat samples");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* sim.f */
hw/music_pkg.sv
hw/song_mem.sv
hw/beat_generator.sv
hw/voice_arbiter.sv
hw/note_player.sv
hw/song_reader.sv
hw/music_top.sv
verification/music_props.sv
verification/music_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module music_tb -f sim.f
./obj_dir/Vmusic_tb

/* verification/music_vectors.txt */
# L addr word | P play | E done pos voice1 voice2 voice3, checked the cycle after the next beat
# H cycles done pos voice1 voice2 voice3, checked every cycle, all hex except cycles
# notes 10 and 20 take voices 1 and 2, then a wait of 2 beats
L 00 1410
L 01 2820
L 02 8400
# note 30 takes voice 1, note 40 is forced onto busy voice 2 and stalls
# note 50 then finds voice 3 as the lowest free one
L 03 3C18
L 04 5014
L 05 6410
L 06 8400
# a note of duration 0, a note forced onto voice 3, then the last wait
L 07 7800
L 08 0A1E
L 09 8500
P 1
E 0 02 4A 54 00
E 0 03 00 54 00
E 0 04 5E 54 00
E 0 04 5E 00 00
E 0 06 00 68 72
# pause inside the second wait, position and notes freeze
P 0
H 30 0 06 00 68 72
P 1
E 0 07 00 00 00
E 0 09 00 00 45
E 1 00 00 00 45
E 0 00 00 00 00
# song over, nothing starts while play stays high
H 20 0 00 00 00 00
# a fresh rising edge of play replays the song
P 0
P 1
E 0 02 4A 54 00
E 0 03 00 54 00
E 0 04 5E 54 00
E 0 04 5E 00 00
E 0 06 00 68 72
